//--- Makefile
TOP := tb_ex_stage

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }

lint:
	verilator --lint-only -Wall --top-module ex_stage \
		source/ex_pkg.sv source/ex_bus_if.sv source/ex_decode.sv \
		source/ex_alu.sv source/ex_result.sv source/ex_stage.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- project.f
+incdir+sim
source/ex_pkg.sv
source/ex_bus_if.sv
source/ex_decode.sv
source/ex_alu.sv
source/ex_result.sv
source/ex_stage.sv
sim/tb_ex_stage.sv

//--- sim/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected outputs of one instruction one cycle later
typedef struct packed {
    logic        wr_en;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        jump_en;
    logic [31:0] jump_addr;
} expect_t;

// alt picks sub or sra for the rv32i integer op in funct3
function automatic logic [31:0] alu_result_of(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << sh;
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5: begin
            if (alt)
                return $unsigned($signed(a) >>> sh);
            return a >> sh;
        end
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic expect_t predict_outputs(input logic [31:0] ins, input logic [31:0] pc,
                                            input logic [31:0] rs1, input logic [31:0] rs2);
    expect_t     e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    e     = '0;
    f3    = ins[14:12];
    f7    = ins[31:25];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'b0};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    case (ins[6:0])
        7'b0010011: begin // op-imm
            if (f3 == 3'd1)
                e.wr_en = (f7 == 7'h00);
            else if (f3 == 3'd5)
                e.wr_en = (f7 == 7'h00) || (f7 == 7'h20);
            else
                e.wr_en = 1'b1;
            e.rd_data = alu_result_of(f3, (f3 == 3'd5) && (f7 == 7'h20), rs1, imm_i);
        end
        7'b0110011: begin // mul/div funct7 gives no write
            e.wr_en   = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
            e.rd_data = alu_result_of(f3, f7 == 7'h20, rs1, rs2);
        end
        7'b0110111: begin // lui
            e.wr_en   = 1'b1;
            e.rd_data = imm_u;
        end
        7'b0010111: begin // auipc
            e.wr_en   = 1'b1;
            e.rd_data = pc + imm_u;
        end
        7'b1101111: begin // jal
            e.wr_en     = 1'b1;
            e.rd_data   = pc + 32'd4;
            e.jump_en   = 1'b1;
            e.jump_addr = pc + imm_j;
        end
        7'b1100111: begin // jalr is defined for funct3 zero only
            e.wr_en     = (f3 == 3'd0);
            e.rd_data   = pc + 32'd4;
            e.jump_en   = (f3 == 3'd0);
            e.jump_addr = rs1 + imm_i;
        end
        7'b1100011: begin
            case (f3)
                3'd0:    e.jump_en = (rs1 == rs2);
                3'd1:    e.jump_en = (rs1 != rs2);
                3'd4:    e.jump_en = ($signed(rs1) < $signed(rs2));
                3'd5:    e.jump_en = ($signed(rs1) >= $signed(rs2));
                3'd6:    e.jump_en = (rs1 < rs2);
                3'd7:    e.jump_en = (rs1 >= rs2);
                default: e.jump_en = 1'b0;
            endcase
            e.jump_addr = pc + imm_b;
        end
        default: ;
    endcase

    // idle outputs read as zero
    e.rd_addr = e.wr_en ? ins[11:7] : 5'd0;
    if (!e.wr_en)
        e.rd_data = '0;
    if (!e.jump_en)
        e.jump_addr = '0;
    return e;
endfunction

`endif

//--- sim/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    `include "ex_ref_model.svh"

    localparam int reset_cycles = 10;
    localparam int test_len     = 200;
    localparam int num_tests    = 6;
    // reset plus each test with its three drain cycles plus margin up to 2000
    localparam int max_cycles   = reset_cycles + num_tests * (test_len + 3) + 772;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] ins_i;
    logic [31:0] ins_addr_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic [4:0]  rd_addr_o;
    logic [31:0] rd_data_o;
    logic        rd_wr_en_o;
    logic [31:0] jump_addr_o;
    logic        jump_en_o;

    expect_t     now_exp;
    expect_t     exp_q;  // lines up with the DUT register
    string       test_name = "reset";
    int          errors = 0;
    int          tests_run = 0;
    int          failed_tests = 0;
    int          cycles = 0;

    ex_stage ex_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .ins_i       (ins_i),
        .ins_addr_i  (ins_addr_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o),
        .rd_wr_en_o  (rd_wr_en_o),
        .jump_addr_o (jump_addr_o),
        .jump_en_o   (jump_en_o)
    );

    always #5 clk = ~clk;

    assign now_exp = predict_outputs(ins_i, ins_addr_i, rs1_data_i, rs2_data_i);

    always @(posedge clk or posedge rst) begin
        if (rst)
            exp_q <= '0;
        else
            exp_q <= now_exp;
    end

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        errors++;
        $display("** Error %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
    endtask

    // outputs are stable at the falling edge
    assert property (@(negedge clk) rst |-> !rd_wr_en_o && !jump_en_o)
        else begin
            errors++;
            $display("** Error %s: write or jump enable raised during reset", test_name);
        end
    assert property (@(negedge clk) disable iff (rst) rd_wr_en_o == exp_q.wr_en)
        else report_mismatch("rd_wr_en_o", 32'(exp_q.wr_en), 32'(rd_wr_en_o));
    assert property (@(negedge clk) disable iff (rst) rd_addr_o == exp_q.rd_addr)
        else report_mismatch("rd_addr_o", 32'(exp_q.rd_addr), 32'(rd_addr_o));
    assert property (@(negedge clk) disable iff (rst) rd_data_o == exp_q.rd_data)
        else report_mismatch("rd_data_o", exp_q.rd_data, rd_data_o);
    assert property (@(negedge clk) disable iff (rst) jump_en_o == exp_q.jump_en)
        else report_mismatch("jump_en_o", 32'(exp_q.jump_en), 32'(jump_en_o));
    assert property (@(negedge clk) disable iff (rst) jump_addr_o == exp_q.jump_addr)
        else report_mismatch("jump_addr_o", exp_q.jump_addr, jump_addr_o);

    // random fields under a chosen opcode, funct3 and funct7
    task automatic send(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7);
        logic [31:0] ins;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        ins        = $urandom;
        ins[6:0]   = opc;
        ins[14:12] = f3;
        ins[31:25] = f7;
        pc         = $urandom;
        pc[1:0]    = 2'b00;
        a          = $urandom;
        b          = ($urandom_range(0, 3) == 0) ? a : $urandom; // equal operands now and then
        @(posedge clk);
        ins_i      <= ins;
        ins_addr_i <= pc;
        rs1_data_i <= a;
        rs2_data_i <= b;
    endtask

    task automatic send_kind(input int kind);
        logic [2:0] f3;
        logic [6:0] f7;
        int         pick;
        f3   = 3'($urandom);
        f7   = 7'($urandom);
        pick = $urandom_range(0, 3);
        case (kind)
            0: send(7'b0110011, f3, pick[0] ? 7'h20 : 7'h00);
            1: send(7'b0010011, f3, (pick == 0) ? 7'h00 : (pick == 1) ? 7'h20 : f7);
            2: begin
                case (pick)
                    0:       send(7'b0110111, f3, f7);   // lui
                    1:       send(7'b0010111, f3, f7);   // auipc
                    2:       send(7'b1101111, f3, f7);   // jal
                    default: send(7'b1100111, 3'b000, f7);
                endcase
            end
            3: send(7'b1100011, f3, f7);
            default: begin
                case (pick)
                    0:       send(7'b0110011, f3, 7'h01); // mul/div
                    1:       send(7'b0000011, f3, f7);    // load
                    2:       send(7'b0100011, f3, f7);    // store
                    default: send(7'b0001011, f3, f7);    // custom-0
                endcase
            end
        endcase
    endtask

    task automatic close_test(input int count, input int start_errors);
        int errs;
        errs = errors - start_errors;
        tests_run++;
        if (errs != 0)
            failed_tests++;
        $display("%-12s %0d instructions, %0d errors", test_name, count, errs);
    endtask

    // kind 5 mixes all the others
    task automatic run_test(input string name, input int kind);
        int start_errors;
        test_name    = name;
        start_errors = errors;
        for (int i = 0; i < test_len; i++)
            send_kind((kind == 5) ? $urandom_range(0, 4) : kind);
        @(posedge clk);
        ins_i <= '0;
        repeat (2) @(posedge clk); // last check has run
        close_test(test_len, start_errors);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'he8d6_fcd9));
        rst        = 1'b1;
        ins_i      = '0;
        ins_addr_i = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        close_test(0, 0);

        run_test("reg_ops", 0);
        run_test("imm_ops", 1);
        run_test("upper_jump", 2);
        run_test("branches", 3);
        run_test("illegal", 4);
        run_test("mixed", 5);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- source/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    ex_bus_if.alu_mp bus
);

    logic [4:0]    shamt;
    ex_pkg::word_t sum;
    ex_pkg::word_t diff;
    ex_pkg::word_t sra_res;

    assign shamt = bus.op2[4:0]; // only low 5 bits shift

    assign sum     = bus.op1 + bus.op2;
    assign diff    = bus.op1 - bus.op2;
    assign sra_res = $signed(bus.op1) >>> shamt;

    // compare flags feed the branch decision too
    assign bus.eq   = (bus.op1 == bus.op2);
    assign bus.lt_s = ($signed(bus.op1) < $signed(bus.op2));
    assign bus.lt_u = (bus.op1 < bus.op2);

    always_comb begin
        case (bus.alu_op)
            ex_pkg::alu_add:  bus.alu_result = sum;
            ex_pkg::alu_sub:  bus.alu_result = diff;
            ex_pkg::alu_and:  bus.alu_result = bus.op1 & bus.op2;
            ex_pkg::alu_or:   bus.alu_result = bus.op1 | bus.op2;
            ex_pkg::alu_xor:  bus.alu_result = bus.op1 ^ bus.op2;
            ex_pkg::alu_sll:  bus.alu_result = bus.op1 << shamt;
            ex_pkg::alu_srl:  bus.alu_result = bus.op1 >> shamt;
            ex_pkg::alu_sra:  bus.alu_result = sra_res;
            ex_pkg::alu_slt:  bus.alu_result = {{(ex_pkg::xlen-1){1'b0}}, bus.lt_s};
            ex_pkg::alu_sltu: bus.alu_result = {{(ex_pkg::xlen-1){1'b0}}, bus.lt_u};
            default:          bus.alu_result = '0;
        endcase
    end

    // jump and branch target
    assign bus.target = bus.tgt_base + bus.tgt_offset;

endmodule

//--- source/ex_bus_if.sv
`timescale 1ns/1ps

interface ex_bus_if;

    // decode to alu
    ex_pkg::word_t     op1;
    ex_pkg::word_t     op2;
    ex_pkg::alu_op_t   alu_op;
    ex_pkg::word_t     tgt_base;
    ex_pkg::word_t     tgt_offset;

    // decode to result
    ex_pkg::reg_addr_t rd_addr;
    logic              wr_en;
    logic              is_branch;
    logic              is_jump;
    ex_pkg::br_cond_t  br_cond;

    // alu to result
    ex_pkg::word_t     alu_result;
    logic              eq;
    logic              lt_s;
    logic              lt_u;
    ex_pkg::word_t     target;

    modport decode_mp (
        output op1, op2, alu_op, tgt_base, tgt_offset,
        output rd_addr, wr_en, is_branch, is_jump, br_cond
    );

    modport alu_mp (
        input  op1, op2, alu_op, tgt_base, tgt_offset,
        output alu_result, eq, lt_s, lt_u, target
    );

    modport result_mp (
        input rd_addr, wr_en, is_branch, is_jump, br_cond,
        input alu_result, eq, lt_s, lt_u, target
    );

endinterface

//--- source/ex_decode.sv
`timescale 1ns/1ps

module ex_decode (
    input  ex_pkg::word_t ins_i,
    input  ex_pkg::word_t ins_addr_i,
    input  ex_pkg::word_t rs1_data_i,
    input  ex_pkg::word_t rs2_data_i,
    ex_bus_if.decode_mp   bus
);

    ex_pkg::opcode_t   opcode;
    ex_pkg::reg_addr_t rd;
    ex_pkg::funct3_t   funct3;
    ex_pkg::funct7_t   funct7;

    ex_pkg::word_t imm_i;
    ex_pkg::word_t imm_u;
    ex_pkg::word_t imm_b;
    ex_pkg::word_t imm_j;

    logic imm_alt; // srai only
    logic reg_alt;

    assign opcode = ins_i[6:0];
    assign rd     = ins_i[11:7];
    assign funct3 = ins_i[14:12];
    assign funct7 = ins_i[31:25];

    assign imm_i = {{21{ins_i[31]}}, ins_i[30:20]};
    assign imm_u = {ins_i[31:12], 12'h000};
    assign imm_b = {{20{ins_i[31]}}, ins_i[7], ins_i[30:25], ins_i[11:8], 1'b0};
    assign imm_j = {{12{ins_i[31]}}, ins_i[19:12], ins_i[20], ins_i[30:21], 1'b0};

    // funct7 of an immediate op is part of the immediate except for shifts
    assign imm_alt = (funct3 == ex_pkg::f3_sr) && (funct7 == ex_pkg::f7_alt);
    assign reg_alt = (funct7 == ex_pkg::f7_alt);

    function automatic ex_pkg::alu_op_t alu_sel(input ex_pkg::funct3_t f3, input logic alt);
        ex_pkg::alu_op_t op;
        case (f3)
            ex_pkg::f3_add:  op = alt ? ex_pkg::alu_sub : ex_pkg::alu_add;
            ex_pkg::f3_sll:  op = ex_pkg::alu_sll;
            ex_pkg::f3_slt:  op = ex_pkg::alu_slt;
            ex_pkg::f3_sltu: op = ex_pkg::alu_sltu;
            ex_pkg::f3_xor:  op = ex_pkg::alu_xor;
            ex_pkg::f3_sr:   op = alt ? ex_pkg::alu_sra : ex_pkg::alu_srl;
            ex_pkg::f3_or:   op = ex_pkg::alu_or;
            default:         op = ex_pkg::alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        bus.op1        = rs1_data_i;
        bus.op2        = rs2_data_i;
        bus.alu_op     = ex_pkg::alu_add;
        bus.tgt_base   = ins_addr_i;
        bus.tgt_offset = imm_b;
        bus.rd_addr    = rd;
        bus.wr_en      = 1'b0;
        bus.is_branch  = 1'b0;
        bus.is_jump    = 1'b0;
        bus.br_cond    = funct3;

        case (opcode)
            ex_pkg::op_imm: begin
                bus.op2    = imm_i;
                bus.alu_op = alu_sel(funct3, imm_alt);
                case (funct3)
                    ex_pkg::f3_sll: bus.wr_en = (funct7 == ex_pkg::f7_base);
                    ex_pkg::f3_sr:  bus.wr_en = (funct7 == ex_pkg::f7_base) || imm_alt;
                    default:        bus.wr_en = 1'b1;
                endcase
            end
            ex_pkg::op_reg: begin
                bus.alu_op = alu_sel(funct3, reg_alt);
                // mul/div funct7 falls out here too
                bus.wr_en  = (funct7 == ex_pkg::f7_base) ||
                             (reg_alt && (funct3 == ex_pkg::f3_add || funct3 == ex_pkg::f3_sr));
            end
            ex_pkg::op_lui: begin
                bus.op1   = '0;
                bus.op2   = imm_u;
                bus.wr_en = 1'b1;
            end
            ex_pkg::op_auipc: begin
                bus.op1   = ins_addr_i;
                bus.op2   = imm_u;
                bus.wr_en = 1'b1;
            end
            ex_pkg::op_jal: begin
                bus.op1        = ins_addr_i;         // link
                bus.op2        = ex_pkg::insn_bytes;
                bus.tgt_offset = imm_j;
                bus.wr_en      = 1'b1;
                bus.is_jump    = 1'b1;
            end
            ex_pkg::op_jalr: begin
                bus.op1        = ins_addr_i;
                bus.op2        = ex_pkg::insn_bytes;
                bus.tgt_base   = rs1_data_i;         // bit 0 kept as is
                bus.tgt_offset = imm_i;
                bus.wr_en      = (funct3 == ex_pkg::f3_jalr);
                bus.is_jump    = (funct3 == ex_pkg::f3_jalr);
            end
            ex_pkg::op_branch: begin
                bus.alu_op = ex_pkg::alu_sub;
                case (funct3)
                    ex_pkg::br_beq, ex_pkg::br_bne,
                    ex_pkg::br_blt, ex_pkg::br_bge,
                    ex_pkg::br_bltu, ex_pkg::br_bgeu: bus.is_branch = 1'b1;
                    default:                          bus.is_branch = 1'b0;
                endcase
            end
            default: ; // loads, stores, unknown
        endcase
    end

    // a branch never writes and never counts as an unconditional jump
    always_comb begin
        assert (!(bus.is_branch && (bus.wr_en || bus.is_jump)))
            else $error("decode: branch flagged together with write or jump");
    end

endmodule

//--- source/ex_pkg.sv
package ex_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [2:0]      br_cond_t;

    // rv32i major opcodes
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;

    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000; // sub, sra, srai

    // funct3 shared by op_imm and op_reg
    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;
    localparam funct3_t f3_jalr = 3'b000;

    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_and  = 4'd2;
    localparam alu_op_t alu_or   = 4'd3;
    localparam alu_op_t alu_xor  = 4'd4;
    localparam alu_op_t alu_sll  = 4'd5;
    localparam alu_op_t alu_srl  = 4'd6;
    localparam alu_op_t alu_sra  = 4'd7;
    localparam alu_op_t alu_slt  = 4'd8;
    localparam alu_op_t alu_sltu = 4'd9;

    // same values as the branch funct3
    localparam br_cond_t br_beq  = 3'b000;
    localparam br_cond_t br_bne  = 3'b001;
    localparam br_cond_t br_blt  = 3'b100;
    localparam br_cond_t br_bge  = 3'b101;
    localparam br_cond_t br_bltu = 3'b110;
    localparam br_cond_t br_bgeu = 3'b111;

    localparam word_t insn_bytes = 32'd4; // link offset

endpackage

//--- source/ex_result.sv
`timescale 1ns/1ps

module ex_result (
    input  logic                clk,
    input  logic                rst,
    ex_bus_if.result_mp         bus,
    output ex_pkg::reg_addr_t   rd_addr_o,
    output ex_pkg::word_t       rd_data_o,
    output logic                rd_wr_en_o,
    output ex_pkg::word_t       jump_addr_o,
    output logic                jump_en_o
);

    logic cond_met;
    logic take;
    logic branch_q; // last registered instruction was a branch

    always_comb begin
        case (bus.br_cond)
            ex_pkg::br_beq:  cond_met = bus.eq;
            ex_pkg::br_bne:  cond_met = !bus.eq;
            ex_pkg::br_blt:  cond_met = bus.lt_s;
            ex_pkg::br_bge:  cond_met = !bus.lt_s;
            ex_pkg::br_bltu: cond_met = bus.lt_u;
            ex_pkg::br_bgeu: cond_met = !bus.lt_u;
            default:         cond_met = 1'b0;
        endcase
    end

    assign take = bus.is_jump || (bus.is_branch && cond_met);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_wr_en_o  <= 1'b0;
            rd_addr_o   <= '0;
            rd_data_o   <= '0;
            jump_en_o   <= 1'b0;
            jump_addr_o <= '0;
            branch_q    <= 1'b0;
        end else begin
            rd_wr_en_o  <= bus.wr_en;
            rd_addr_o   <= bus.wr_en ? bus.rd_addr : '0;
            rd_data_o   <= bus.wr_en ? bus.alu_result : '0; // zero when no write
            jump_en_o   <= take;
            jump_addr_o <= take ? bus.target : '0;
            branch_q    <= bus.is_branch;
        end
    end

    // nothing leaks out on the first edge after reset
    assert property (@(posedge clk) $fell(rst) |-> !rd_wr_en_o && !jump_en_o)
        else $error("result: write or jump right after reset");

    // pc relative targets stay halfword aligned for an aligned pc
    assert property (@(posedge clk) disable iff (rst)
        jump_en_o && branch_q |-> !jump_addr_o[0])
        else $error("result: odd branch target %h", jump_addr_o);

endmodule

//--- source/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              rst,
    input  ex_pkg::word_t     ins_i,
    input  ex_pkg::word_t     ins_addr_i,
    input  ex_pkg::word_t     rs1_data_i,
    input  ex_pkg::word_t     rs2_data_i,
    output ex_pkg::reg_addr_t rd_addr_o,
    output ex_pkg::word_t     rd_data_o,
    output logic              rd_wr_en_o,
    output ex_pkg::word_t     jump_addr_o,
    output logic              jump_en_o
);

    ex_bus_if ex_bus ();

    ex_decode decode_inst (
        .ins_i      (ins_i),
        .ins_addr_i (ins_addr_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .bus        (ex_bus)
    );

    ex_alu alu_inst (
        .bus (ex_bus)
    );

    // only registered stage
    ex_result result_inst (
        .clk         (clk),
        .rst         (rst),
        .bus         (ex_bus),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o),
        .rd_wr_en_o  (rd_wr_en_o),
        .jump_addr_o (jump_addr_o),
        .jump_en_o   (jump_en_o)
    );

endmodule
